// ==== include/mem_params.svh ====
// Sizes for the three-read, one-write replicated memory.
// MEM_NUM_WORDS must equal 2**MEM_ADDR_BITS, as the clearing sweep wraps on it.
// MEM_RD_LATENCY describes the fixed read pipeline and is not a tuning knob.

`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Data word width in bits
`define MEM_DATA_WIDTH 32

// Word address width and word count
`define MEM_ADDR_BITS 6
`define MEM_NUM_WORDS 64

// One replica bank per read port
`define MEM_NUM_RD 3

// Cycles from an accepted read strobe to rd_vld
`define MEM_RD_LATENCY 2

`endif

// ==== hdl/mem_pkg.sv ====
// Address and data types shared by the memory and its testbench.
// Widths come from mem_params.svh.

`default_nettype none

`include "mem_params.svh"

package mem_pkg;

  // Word address into every replica
  typedef logic [`MEM_ADDR_BITS-1:0] mem_addr_t;

  // One stored data word
  typedef logic [`MEM_DATA_WIDTH-1:0] mem_data_t;

endpackage

`default_nettype wire

// ==== hdl/write_fanout.sv ====
// Write side of the replicated memory.
// After reset a sweep writes zero to every word, one per cycle, with ready low.
// User writes are dropped until ready rises, then go to all replicas at once.
// A write seen with ready high is always taken at that edge.

`default_nettype none

`include "mem_params.svh"

module write_fanout import mem_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  // User write port
  input  logic      write,
  input  mem_addr_t wr_adr,
  input  mem_data_t din,
  // High once the clearing sweep is done
  output logic      ready,
  // Write bus shared by every replica
  output logic      bank_wr_en,
  output mem_addr_t bank_wr_adr,
  output mem_data_t bank_wr_data
);

  mem_addr_t sweep_adr;   // Next word to clear
  logic      sweep_last;

  assign sweep_last = (sweep_adr == mem_addr_t'(`MEM_NUM_WORDS - 1));

  // Sweep counter and ready flag
  always_ff @(posedge clk) begin
    if (reset) begin
      sweep_adr <= '0;
      ready     <= 1'b0;
    end else if (!ready) begin
      sweep_adr <= sweep_adr + 1'b1;   // Wraps back to zero after the last word
      if (sweep_last) begin
        ready <= 1'b1;
      end
    end
  end

  // Clearing writes while sweeping, user writes afterwards
  always_comb begin
    if (ready) begin
      bank_wr_en   = write;
      bank_wr_adr  = wr_adr;
      bank_wr_data = din;
    end else begin
      bank_wr_en   = 1'b1;
      bank_wr_adr  = sweep_adr;
      bank_wr_data = '0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/replica_bank.sv ====
// One write, one read storage bank holding a full copy of the memory.
// Read data is registered, one cycle after rd_en.
// A read and a write to the same word at one edge returns the old word.
// Contents are undefined until the clearing sweep has written every word.

`default_nettype none

`include "mem_params.svh"

module replica_bank import mem_pkg::*; (
  input  logic      clk,
  // Write port shared by all replicas
  input  logic      wr_en,
  input  mem_addr_t wr_adr,
  input  mem_data_t wr_data,
  // Read port private to one external read port
  input  logic      rd_en,
  input  mem_addr_t rd_adr,
  output mem_data_t rd_data
);

  mem_data_t mem [`MEM_NUM_WORDS];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_adr] <= wr_data;
    end
    // Samples the array before the write above lands
    if (rd_en) begin
      rd_data <= mem[rd_adr];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/read_collector.sv ====
// Read side of the replicated memory.
// Each read port drives only its own replica.
// Strobes are taken only while ready is high and come back exactly two
// cycles later on rd_vld, with the word registered into rd_dout.
// Every port may issue a read each cycle without back-pressure.

`default_nettype none

`include "mem_params.svh"

module read_collector import mem_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          ready,
  // External read ports
  input  logic      [`MEM_NUM_RD-1:0]   read,
  input  mem_addr_t [`MEM_NUM_RD-1:0]   rd_adr,
  // One read port per replica
  output logic      [`MEM_NUM_RD-1:0]   bank_rd_en,
  output mem_addr_t [`MEM_NUM_RD-1:0]   bank_rd_adr,
  input  mem_data_t [`MEM_NUM_RD-1:0]   bank_rd_data,
  // Returned data
  output logic      [`MEM_NUM_RD-1:0]   rd_vld,
  output mem_data_t [`MEM_NUM_RD-1:0]   rd_dout
);

  logic [`MEM_NUM_RD-1:0] vld_s1;   // Replica data valid this cycle

  // Reads during the clearing sweep are dropped here
  assign bank_rd_en  = read & {`MEM_NUM_RD{ready}};
  assign bank_rd_adr = rd_adr;

  // Two-stage valid pipeline
  always_ff @(posedge clk) begin
    if (reset) begin
      vld_s1 <= '0;
      rd_vld <= '0;
    end else begin
      vld_s1 <= bank_rd_en;
      rd_vld <= vld_s1;
    end
  end

  // Second stage holds the word alongside rd_vld
  always_ff @(posedge clk) begin
    for (int i = 0; i < `MEM_NUM_RD; i++) begin
      if (vld_s1[i]) begin
        rd_dout[i] <= bank_rd_data[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/multiport_mem_top.sv ====
// Three-read, one-write memory built from one replica bank per read port.
// Every write is broadcast to all replicas; each read port reads its own.
// ready stays low for MEM_NUM_WORDS cycles after reset while words clear.
// Read data follows an accepted strobe by exactly MEM_RD_LATENCY cycles.

`default_nettype none

`include "mem_params.svh"

module multiport_mem_top import mem_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  // Write port
  input  logic                          write,
  input  mem_addr_t                     wr_adr,
  input  mem_data_t                     din,
  // Read ports
  input  logic      [`MEM_NUM_RD-1:0]   read,
  input  mem_addr_t [`MEM_NUM_RD-1:0]   rd_adr,
  // Status and read return
  output logic                          ready,
  output logic      [`MEM_NUM_RD-1:0]   rd_vld,
  output mem_data_t [`MEM_NUM_RD-1:0]   rd_dout
);

  // Shared write bus
  logic      bank_wr_en;
  mem_addr_t bank_wr_adr;
  mem_data_t bank_wr_data;

  // Per-replica read ports
  logic      [`MEM_NUM_RD-1:0] bank_rd_en;
  mem_addr_t [`MEM_NUM_RD-1:0] bank_rd_adr;
  mem_data_t [`MEM_NUM_RD-1:0] bank_rd_data;

  write_fanout i_write_fanout (
    .clk          (clk),
    .reset        (reset),
    .write        (write),
    .wr_adr       (wr_adr),
    .din          (din),
    .ready        (ready),
    .bank_wr_en   (bank_wr_en),
    .bank_wr_adr  (bank_wr_adr),
    .bank_wr_data (bank_wr_data)
  );

  for (genvar i = 0; i < `MEM_NUM_RD; i++) begin : g_replica
    replica_bank i_replica_bank (
      .clk     (clk),
      .wr_en   (bank_wr_en),
      .wr_adr  (bank_wr_adr),
      .wr_data (bank_wr_data),
      .rd_en   (bank_rd_en[i]),
      .rd_adr  (bank_rd_adr[i]),
      .rd_data (bank_rd_data[i])
    );
  end

  read_collector i_read_collector (
    .clk          (clk),
    .reset        (reset),
    .ready        (ready),
    .read         (read),
    .rd_adr       (rd_adr),
    .bank_rd_en   (bank_rd_en),
    .bank_rd_adr  (bank_rd_adr),
    .bank_rd_data (bank_rd_data),
    .rd_vld       (rd_vld),
    .rd_dout      (rd_dout)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_multiport_mem.sv ====
// Testbench for the replicated three-read, one-write memory.
// Inputs change on the falling edge, and outputs are checked there as well.
// Expected read data comes from a model array of the accepted writes.
// Stops at the first mismatch, with a watchdog bounding the run time.

`default_nettype none

`include "mem_params.svh"

module tb_multiport_mem import mem_pkg::*; ();

  typedef mem_addr_t [`MEM_NUM_RD-1:0] rd_adr_t;

  localparam int N_RANDOM  = 300;   // Cycles of random traffic
  localparam int N_DIRECT  = 8;     // Addresses per directed test
  localparam int TOTAL_OPS = 4 * `MEM_NUM_WORDS + N_RANDOM + 8 * N_DIRECT;
  localparam int TIMEOUT   = 20 * 4 * (`MEM_NUM_WORDS + TOTAL_OPS);

  logic                        clk = 1'b0;
  logic                        reset;
  logic                        write;
  mem_addr_t                   wr_adr;
  mem_data_t                   din;
  logic      [`MEM_NUM_RD-1:0] read;
  rd_adr_t                     rd_adr;
  logic                        ready;
  logic      [`MEM_NUM_RD-1:0] rd_vld;
  mem_data_t [`MEM_NUM_RD-1:0] rd_dout;

  mem_data_t model [`MEM_NUM_WORDS];
  logic      model_live;    // Model cleared since ready last rose
  int        cycle_cnt = 0;

  // Expected word and issue cycle of every outstanding read per port
  mem_data_t exp_data_q [`MEM_NUM_RD][$];
  int        exp_cyc_q  [`MEM_NUM_RD][$];

  multiport_mem_top i_dut (
    .clk     (clk),
    .reset   (reset),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .ready   (ready),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // A read sees the word as it was before a write at the same edge
  function automatic mem_data_t expected_word(input mem_addr_t adr);
    return model[adr];
  endfunction

  function automatic void clear_model();
    for (int a = 0; a < `MEM_NUM_WORDS; a++) begin
      model[a] = '0;
    end
  endfunction

  task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string what, input mem_data_t actual,
                             input mem_data_t expected);
    if (actual !== expected) begin
      $display("ERROR: t=%0t %s mismatch, got %h, expected %h",
               $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  // Drives one cycle and queues what each accepted read should return
  task automatic drive_cycle(input logic wr, input mem_addr_t wa, input mem_data_t wd,
                             input logic [`MEM_NUM_RD-1:0] rd, input rd_adr_t ra);
    @(negedge clk);
    write  = wr;
    wr_adr = wa;
    din    = wd;
    read   = rd;
    rd_adr = ra;
    if (ready === 1'b1) begin
      if (!model_live) begin
        clear_model();   // Sweep has just finished
        model_live = 1'b1;
      end
      for (int p = 0; p < `MEM_NUM_RD; p++) begin
        if (rd[p]) begin
          exp_data_q[p].push_back(expected_word(ra[p]));
          exp_cyc_q[p].push_back(cycle_cnt);
        end
      end
      if (wr) begin
        model[wa] = wd;
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0, '0, '0, '0);
  endtask

  task automatic read_all_ports(input mem_addr_t adr);
    drive_cycle(1'b0, '0, '0, '1, {`MEM_NUM_RD{adr}});
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    write = 1'b0;
    read  = '0;
    model_live = 1'b0;
    repeat (5) @(negedge clk);
    if (ready !== 1'b0 || rd_vld !== '0) begin
      $display("ready or rd_vld was high during reset");
      stop_with_failure();
    end
    reset = 1'b0;
  endtask

  task automatic compare_port(input int p);
    int        issued;
    mem_data_t exp_word;
    if (rd_vld[p] === 1'b1) begin
      if (exp_data_q[p].size() == 0) begin
        $display("Port %0d raised rd_vld with no read outstanding", p);
        stop_with_failure();
      end else begin
        exp_word = exp_data_q[p].pop_front();
        issued   = exp_cyc_q[p].pop_front();
        check_value($sformatf("port %0d read latency", p),
                    mem_data_t'(cycle_cnt - issued), mem_data_t'(`MEM_RD_LATENCY));
        check_value($sformatf("port %0d read data", p), rd_dout[p], exp_word);
      end
    end else if (exp_cyc_q[p].size() != 0 &&
                 cycle_cnt - exp_cyc_q[p][0] > `MEM_RD_LATENCY) begin
      $display("Port %0d read issued in cycle %0d never returned", p, exp_cyc_q[p][0]);
      stop_with_failure();
    end
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      if (ready !== 1'b1 && rd_vld !== '0) begin
        $display("rd_vld was raised while the memory was not ready");
        stop_with_failure();
      end
      for (int p = 0; p < `MEM_NUM_RD; p++) begin
        compare_port(p);
      end
    end
  end

  task automatic wait_for_ready();
    while (ready !== 1'b1) begin
      idle_cycles(1);
    end
  endtask

  task automatic read_every_word();
    for (int a = 0; a < `MEM_NUM_WORDS; a++) begin
      read_all_ports(mem_addr_t'(a));
    end
    idle_cycles(`MEM_RD_LATENCY + 1);
  endtask

  task automatic write_then_read();
    mem_addr_t adr;
    for (int n = 0; n < N_DIRECT; n++) begin
      adr = mem_addr_t'($urandom);
      drive_cycle(1'b1, adr, mem_data_t'($urandom), '0, '0);
      read_all_ports(adr);
    end
    idle_cycles(`MEM_RD_LATENCY + 1);
  endtask

  task automatic random_traffic();
    rd_adr_t   ra;
    mem_addr_t wa;
    logic      wr;
    for (int n = 0; n < N_RANDOM; n++) begin
      // Offsets keep the three read addresses distinct
      ra[0] = mem_addr_t'($urandom);
      ra[1] = ra[0] + mem_addr_t'(1 + $urandom % 21);
      ra[2] = ra[0] + mem_addr_t'(22 + $urandom % 21);
      wr = ($urandom % 2) == 0;
      wa = ($urandom % 4 == 0) ? ra[0] : mem_addr_t'($urandom);   // Some collisions
      drive_cycle(wr, wa, mem_data_t'($urandom), '1, ra);
    end
    idle_cycles(`MEM_RD_LATENCY + 1);
  endtask

  task automatic same_cycle_collision();
    mem_addr_t adr;
    for (int n = 0; n < N_DIRECT; n++) begin
      adr = mem_addr_t'($urandom);
      drive_cycle(1'b1, adr, mem_data_t'($urandom), '0, '0);
      drive_cycle(1'b1, adr, mem_data_t'($urandom), '1, {`MEM_NUM_RD{adr}});  // Old word
      read_all_ports(adr);   // New word
    end
    idle_cycles(`MEM_RD_LATENCY + 1);
  endtask

  task automatic traffic_during_sweep();
    // Leave nonzero words for the second sweep to clear
    for (int n = 0; n < N_DIRECT; n++) begin
      drive_cycle(1'b1, mem_addr_t'(n * 8), '1, '0, '0);
    end
    idle_cycles(`MEM_RD_LATENCY + 1);
    apply_reset();
    while (ready !== 1'b1) begin
      drive_cycle(1'b1, mem_addr_t'($urandom), mem_data_t'($urandom), '1,
                  rd_adr_t'($urandom));
    end
    idle_cycles(`MEM_RD_LATENCY + 1);
    read_every_word();
  endtask

  initial begin
    #(TIMEOUT);
    $display("Watchdog expired before the tests completed");
    $display("** FAIL **");
    $fatal(1, "Simulation timed out");
  end

  initial begin
    void'($urandom(76));
    reset      = 1'b1;
    write      = 1'b0;
    wr_adr     = '0;
    din        = '0;
    read       = '0;
    rd_adr     = '0;
    model_live = 1'b0;
    apply_reset();
    wait_for_ready();
    read_every_word();
    write_then_read();
    random_traffic();
    same_cycle_collision();
    traffic_during_sweep();
    idle_cycles(`MEM_RD_LATENCY + 2);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hdl/mem_pkg.sv
hdl/write_fanout.sv
hdl/replica_bank.sv
hdl/read_collector.sv
hdl/multiport_mem_top.sv
testbench/tb_multiport_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the memory testbench with Verilator.
# Exit status is nonzero if the build fails or the testbench stops with $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  -f sources.f \
  --top-module tb_multiport_mem \
  --Mdir obj_dir \
  -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished"
exit 0
